// File: design/spiBlock_cfg.svh
// Build-time constants only; BLOCK_NUM must fit in BLOCK_ADRS_BITS, divider wider than 16 untested
`ifndef SPI_BLOCK_CFG_SVH
`define SPI_BLOCK_CFG_SVH

// --------------------
// Bus address layout
// --------------------
`define BUS_ADRS_BITS   32
// Block field sits at the top of the address
`define BLOCK_ADRS_BITS 8
// Block number this instance answers to
`define BLOCK_NUM       'h03

// --------------------
// SPI clock divider
// --------------------
`define SPI_DIV_BITS    16
`define DIV_RESET       4

`endif

// File: design/spiBusPkg.sv
// Register bus types; register select comes from address bits 4:2, word aligned only
package spiBusPkg;

	// --------------------
	// Register select
	// --------------------
	// Values 6 and 7 decode to regNone
	typedef enum logic [2:0]
	{
		regCtrl   = 3'd0,
		regDiv    = 3'd1,
		regLen    = 3'd2,
		regTx     = 3'd3,
		regRx     = 3'd4,
		regStatus = 3'd5,
		regNone   = 3'd7
	} csrReg;

	// --------------------
	// Decoded access
	// --------------------
	// Read strobe already qualified by block match
	typedef struct packed
	{
		logic  rd;
		csrReg sel;
	} busAccess;

endpackage

// File: design/spiLinkPkg.sv
// SPI link types; transfer length of 0 encodes 32 bits, divider width set by the cfg header
`include "spiBlock_cfg.svh"

package spiLinkPkg;

	// Shift engine states
	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		stLow  = 2'd1,
		stHigh = 2'd2,
		stDone = 2'd3
	} engineState;

	// --------------------
	// Transfer settings
	// --------------------
	typedef struct packed
	{
		logic [31:0]                txWord;
		logic [4:0]                 len;    // 0 means 32 bits
		logic [`SPI_DIV_BITS-1:0]   div;
	} spiCmd;

	// Engine result back to readback and decode
	typedef struct packed
	{
		logic [31:0] rxWord;    // Right-aligned
		logic        done;      // One cycle at end of transfer
		logic        busy;
	} spiResult;

endpackage

// File: design/spiCsrDecode.sv
// Register writes take effect at the strobe edge; TX writes while busy or disabled are dropped
`timescale 1ns/1ps
`include "spiBlock_cfg.svh"

module spiCsrDecode
	import spiBusPkg::*;
	import spiLinkPkg::*;
(
	input  logic                      sysClk,
	input  logic                      rst,
	input  logic [31:0]               busWd,
	input  logic [`BUS_ADRS_BITS-1:0] busAdrs,
	input  logic                      busWCke,
	input  logic                      busRCke,
	input  logic                      busy,
	output logic                      start,
	output spiCmd                     cmd,
	output logic                      ctrlEn,
	output busAccess                  acc
);

	logic [`BLOCK_ADRS_BITS-1:0] blkField;
	logic                        hit;
	logic                        wrHit;
	logic                        txAccept;
	csrReg                       sel;
	logic [`SPI_DIV_BITS-1:0]    divReg;
	logic [4:0]                  lenReg;
	logic [31:0]                 txReg;

	// --------------------
	// Address decode
	// --------------------
	// Block field at the top of the address
	assign blkField = busAdrs[`BUS_ADRS_BITS-1 -: `BLOCK_ADRS_BITS];
	assign hit      = (blkField == `BLOCK_NUM);
	assign wrHit    = busWCke & hit;

	// Word index into the register window
	always_comb
	begin
		case (busAdrs[4:2])
			3'd0:    sel = regCtrl;
			3'd1:    sel = regDiv;
			3'd2:    sel = regLen;
			3'd3:    sel = regTx;
			3'd4:    sel = regRx;
			3'd5:    sel = regStatus;
			default: sel = regNone;
		endcase
	end

	// Read strobe qualified by block match
	assign acc.rd  = busRCke & hit;
	assign acc.sel = sel;

	// Only accepted TX writes start a transfer
	assign txAccept = wrHit && (sel == regTx) && ctrlEn && !busy && !start;

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			ctrlEn <= 1'b0;
			divReg <= `DIV_RESET;
			lenReg <= 5'd0;
			txReg  <= 32'd0;
			start  <= 1'b0;
		end
		else
		begin
			start <= txAccept;
			if (wrHit)
			begin
				case (sel)
					regCtrl: ctrlEn <= busWd[0];
					regDiv:  divReg <= busWd[`SPI_DIV_BITS-1:0];
					regLen:  lenReg <= busWd[4:0];
					default: ;
				endcase
			end
			// Dropped TX writes leave the word alone
			if (txAccept)
				txReg <= busWd;
		end
	end

	assign cmd.txWord = txReg;
	assign cmd.len    = lenReg;
	assign cmd.div    = divReg;

	// Bus never issues both strobes at once
	assert property (@(posedge sysClk) disable iff (rst) !(busWCke && busRCke));
	// No start into a running transfer
	assert property (@(posedge sysClk) disable iff (rst) start |-> !busy);

endmodule

// File: design/spiShiftEngine.sv
// SPI mode 0 only, MSB first, single chip select; start is ignored unless the engine is idle
`timescale 1ns/1ps
`include "spiBlock_cfg.svh"

module spiShiftEngine
	import spiLinkPkg::*;
(
	input  logic     sysClk,
	input  logic     rst,
	input  logic     start,
	input  spiCmd    cmd,
	input  logic     spiMiso,
	output logic     spiSck,
	output logic     spiMosi,
	output logic     spiCs,
	output spiResult res
);

	engineState               state;
	logic [`SPI_DIV_BITS-1:0] divReg;
	logic [`SPI_DIV_BITS-1:0] divCnt;
	logic [5:0]               bitsLeft;
	logic [31:0]              shiftTx;
	logic [31:0]              shiftRx;
	logic [5:0]               nBits;
	logic                     halfEnd;

	// Length 0 stands for a full 32-bit word
	assign nBits   = {cmd.len == 5'd0, cmd.len};
	// Last cycle of the current sck half period
	assign halfEnd = (divCnt == divReg);

	// --------------------
	// State machine
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			state    <= stIdle;
			spiCs    <= 1'b1;
			spiSck   <= 1'b0;
			divCnt   <= '0;
			bitsLeft <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (start)
					begin
						state    <= stLow;
						spiCs    <= 1'b0;
						divCnt   <= '0;
						bitsLeft <= nBits;
					end
				end
				stLow:
				begin
					divCnt <= divCnt + 1'b1;
					// Rising sck edge
					if (halfEnd)
					begin
						state  <= stHigh;
						spiSck <= 1'b1;
						divCnt <= '0;
					end
				end
				stHigh:
				begin
					divCnt <= divCnt + 1'b1;
					// Falling sck edge, next bit or finish
					if (halfEnd)
					begin
						spiSck   <= 1'b0;
						divCnt   <= '0;
						bitsLeft <= bitsLeft - 1'b1;
						if (bitsLeft == 6'd1)
						begin
							state <= stDone;
							spiCs <= 1'b1;
						end
						else
						begin
							state <= stLow;
						end
					end
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

	// --------------------
	// Data path
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (state == stIdle && start)
		begin
			divReg  <= cmd.div;
			// Left-align the selected low bits
			shiftTx <= cmd.txWord << (6'd32 - nBits);
			shiftRx <= '0;
		end
		else if (state == stLow && halfEnd)
		begin
			// Sample MISO with sck rising
			shiftRx <= {shiftRx[30:0], spiMiso};
		end
		else if (state == stHigh && halfEnd)
		begin
			// MOSI moves on with sck falling
			shiftTx <= {shiftTx[30:0], 1'b0};
		end
	end

	// MOSI held low between transfers
	assign spiMosi    = ~spiCs & shiftTx[31];
	assign res.rxWord = shiftRx;
	assign res.done   = (state == stDone);
	assign res.busy   = (state == stLow) || (state == stHigh);

	// Chip select stays high while idle
	assert property (@(posedge sysClk) disable iff (rst) (state == stIdle) |-> spiCs);
	// Mode 0 keeps sck low outside a transfer
	assert property (@(posedge sysClk) disable iff (rst) spiCs |-> !spiSck);

endmodule

// File: design/spiReadback.sv
// Read data is registered and zero when no matching read, so several blocks can OR their outputs
`timescale 1ns/1ps

module spiReadback
	import spiBusPkg::*;
	import spiLinkPkg::*;
(
	input  logic        sysClk,
	input  logic        rst,
	input  busAccess    acc,
	input  spiResult    res,
	input  logic        ctrlEn,
	input  spiCmd       cmd,
	output logic [31:0] busRd,
	output logic        busVd
);

	logic [31:0] rxWord;
	logic        rxValid;
	logic [31:0] rdMux;

	// --------------------
	// Received word
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (res.done)
		begin
			rxWord <= res.rxWord;
		end
	end

	// Sticky until RX is read, a new done wins
	always_ff @(posedge sysClk)
	begin
		if (rst)
			rxValid <= 1'b0;
		else if (res.done)
			rxValid <= 1'b1;
		else if (acc.rd && acc.sel == regRx)
			rxValid <= 1'b0;
	end

	// --------------------
	// Read mux
	// --------------------
	always_comb
	begin
		case (acc.sel)
			regCtrl:   rdMux = {31'd0, ctrlEn};
			regDiv:    rdMux = 32'(cmd.div);
			regLen:    rdMux = {27'd0, cmd.len};
			regTx:     rdMux = cmd.txWord;
			regRx:     rdMux = rxWord;
			regStatus: rdMux = {30'd0, rxValid, res.busy};
			default:   rdMux = 32'd0;
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			busVd <= 1'b0;
			busRd <= 32'd0;
		end
		else
		begin
			busVd <= acc.rd;
			busRd <= acc.rd ? rdMux : 32'd0;
		end
	end

endmodule

// File: design/spiBlock.sv
// Top level wiring only; no bus stall, one transfer in flight, plain write and read strobes
`timescale 1ns/1ps
`include "spiBlock_cfg.svh"

module spiBlock
	import spiBusPkg::*;
	import spiLinkPkg::*;
(
	input  logic                      sysClk,
	input  logic                      rst,
	// Register bus
	input  logic [31:0]               busWd,
	input  logic [`BUS_ADRS_BITS-1:0] busAdrs,
	input  logic                      busWCke,
	input  logic                      busRCke,
	output logic [31:0]               busRd,
	output logic                      busVd,
	// SPI pins
	output logic                      spiSck,
	output logic                      spiMosi,
	output logic                      spiCs,
	input  logic                      spiMiso
);

	logic     start;
	logic     ctrlEn;
	spiCmd    cmd;
	busAccess acc;
	spiResult res;

	// --------------------
	// Decode
	// --------------------
	spiCsrDecode csrDecode_i
	(
		.sysClk  (sysClk),
		.rst     (rst),
		.busWd   (busWd),
		.busAdrs (busAdrs),
		.busWCke (busWCke),
		.busRCke (busRCke),
		.busy    (res.busy),
		.start   (start),
		.cmd     (cmd),
		.ctrlEn  (ctrlEn),
		.acc     (acc)
	);

	// Shift engine
	spiShiftEngine shiftEngine_i
	(
		.sysClk  (sysClk),
		.rst     (rst),
		.start   (start),
		.cmd     (cmd),
		.spiMiso (spiMiso),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCs   (spiCs),
		.res     (res)
	);

	// Read-back
	spiReadback readback_i
	(
		.sysClk (sysClk),
		.rst    (rst),
		.acc    (acc),
		.res    (res),
		.ctrlEn (ctrlEn),
		.cmd    (cmd),
		.busRd  (busRd),
		.busVd  (busVd)
	);

endmodule

// File: sim/spiSlaveModel.sv
// Mode 0 slave for simulation only; captures at most 32 MOSI bits per chip-select low period
`timescale 1ns/1ps

module spiSlaveModel
(
	input  logic        spiSck,
	input  logic        spiMosi,
	input  logic        spiCs,
	input  logic [31:0] preload,
	output logic        spiMiso,
	output logic [31:0] captured,
	output logic [5:0]  bitCount
);

	logic [5:0] misoIdx;

	initial
	begin
		captured = '0;
		bitCount = '0;
	end

	// --------------------
	// MOSI capture
	// --------------------
	// sck is low when chip select falls, high on a rising sck
	always @(posedge spiSck or negedge spiCs)
	begin
		if (!spiSck)
		begin
			captured <= '0;
			bitCount <= '0;
		end
		else
		begin
			captured <= {captured[30:0], spiMosi};
			bitCount <= bitCount + 6'd1;
		end
	end

	// Bit index only moves on falling sck
	assign misoIdx = spiSck ? bitCount - 6'd1 : bitCount;
	// Preload goes out top bit first
	assign spiMiso = (misoIdx < 6'd32) ? preload[5'd31 - misoIdx[4:0]] : 1'b0;

endmodule

// File: sim/spiBlockTb.sv
// Checks against block number BLOCK_NUM only; random transfers use dividers 0 to 3
`timescale 1ns/1ps
`include "spiBlock_cfg.svh"

module spiBlockTb
	import spiBusPkg::*;
();

	logic                      sysClk = 1'b0;
	logic                      rst;
	logic [31:0]               busWd;
	logic [`BUS_ADRS_BITS-1:0] busAdrs;
	logic                      busWCke;
	logic                      busRCke;
	logic [31:0]               busRd;
	logic                      busVd;
	logic                      spiSck;
	logic                      spiMosi;
	logic                      spiCs;
	logic                      spiMiso;
	logic [31:0]               preload;
	logic [31:0]               captured;
	logic [5:0]                capCount;
	logic [31:0]               expQ[$];
	string                     nameQ[$];
	logic [31:0]               expData;
	string                     expName;
	int                        errCount = 0;
	int                        timeoutCount = 0;
	int                        lowCycles = 0;
	integer                    seed;

	spiBlock spiBlock_i
	(
		.sysClk  (sysClk),
		.rst     (rst),
		.busWd   (busWd),
		.busAdrs (busAdrs),
		.busWCke (busWCke),
		.busRCke (busRCke),
		.busRd   (busRd),
		.busVd   (busVd),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCs   (spiCs),
		.spiMiso (spiMiso)
	);

	spiSlaveModel slave_i
	(
		.spiSck   (spiSck),
		.spiMosi  (spiMosi),
		.spiCs    (spiCs),
		.preload  (preload),
		.spiMiso  (spiMiso),
		.captured (captured),
		.bitCount (capCount)
	);

	// 100 ns clock
	always #50 sysClk = ~sysClk;

	// --------------------
	// Address and reference
	// --------------------
	function automatic logic [`BUS_ADRS_BITS-1:0] adrsOf(input logic [7:0] blk, input csrReg sel);
		return {blk, {(`BUS_ADRS_BITS - `BLOCK_ADRS_BITS - 5){1'b0}}, sel, 2'b00};
	endfunction

	// Expected MOSI stream and received word, both right-aligned
	function automatic void refXfer(input logic [31:0] tx, input logic [4:0] len,
		input logic [31:0] pre, output logic [31:0] expMosi, output logic [31:0] expRx);
		int nBits;
		nBits = (len == 5'd0) ? 32 : int'(len);
		expMosi = '0;
		expRx = '0;
		for (int i = 0; i < nBits; i++)
		begin
			expMosi = {expMosi[30:0], tx[nBits-1-i]};
			expRx = {expRx[30:0], pre[31-i]};
		end
	endfunction

	// --------------------
	// Read data compare
	// --------------------
	always @(negedge sysClk)
	begin
		if (!rst && busVd)
		begin
			assert (expQ.size() != 0)
			else
			begin
				errCount++;
				$display("Read data valid seen with no matching read pending");
			end
			if (expQ.size() != 0)
			begin
				expData = expQ.pop_front();
				expName = nameQ.pop_front();
				assert (busRd == expData)
				else
				begin
					errCount++;
					$display("[ERROR] busRd (%s) got %h expected %h", expName, busRd, expData);
				end
			end
		end
		else if (!rst)
		begin
			// Idle read data must stay zero for OR-ing
			assert (busRd == 32'd0)
			else
			begin
				errCount++;
				$display("[ERROR] busRd idle got %h expected %h", busRd, 32'd0);
			end
		end
	end

	// Chip-select low time in clock cycles
	always @(negedge sysClk)
	begin
		if (!rst && !spiCs)
			lowCycles++;
	end

	// --------------------
	// Bus tasks
	// --------------------
	task automatic writeReg(input logic [7:0] blk, input csrReg sel, input logic [31:0] data);
		@(negedge sysClk);
		busAdrs = adrsOf(blk, sel);
		busWd = data;
		busWCke = 1'b1;
		@(negedge sysClk);
		busWCke = 1'b0;
	endtask

	// Foreign block reads queue nothing, so any valid is an error
	task automatic readReg(input logic [7:0] blk, input csrReg sel, input logic [31:0] exp,
		input string name);
		int n;
		@(negedge sysClk);
		busAdrs = adrsOf(blk, sel);
		busRCke = 1'b1;
		if (blk == `BLOCK_NUM)
		begin
			expQ.push_back(exp);
			nameQ.push_back(name);
		end
		@(negedge sysClk);
		busRCke = 1'b0;
		n = 0;
		while (expQ.size() != 0 && n < 8)
		begin
			@(negedge sysClk);
			n++;
		end
		if (expQ.size() != 0)
		begin
			timeoutCount++;
			$display("Timeout waiting for read data of %s", name);
			expQ.delete();
			nameQ.delete();
		end
	endtask

	// Chip select low then high again marks one transfer
	task automatic waitXfer(input int limit);
		int n;
		n = 0;
		while (spiCs && n < 16)
		begin
			@(negedge sysClk);
			n++;
		end
		if (spiCs)
		begin
			timeoutCount++;
			$display("Timeout: transfer never started");
		end
		n = 0;
		while (!spiCs && n < limit)
		begin
			@(negedge sysClk);
			n++;
		end
		if (!spiCs)
		begin
			timeoutCount++;
			$display("Timeout: transfer never finished");
		end
	endtask

	task automatic runXfer(input logic [31:0] tx, input logic [4:0] len, input logic [15:0] div,
		input logic [31:0] pre, input bit dropTest);
		logic [31:0] expMosi;
		logic [31:0] expRx;
		int          nBits;
		int          expCycles;
		refXfer(tx, len, pre, expMosi, expRx);
		nBits = (len == 5'd0) ? 32 : int'(len);
		// Each bit is div+1 cycles low and div+1 cycles high
		expCycles = 2 * nBits * (int'(div) + 1);
		preload = pre;
		writeReg(`BLOCK_NUM, regDiv, 32'(div));
		writeReg(`BLOCK_NUM, regLen, 32'(len));
		lowCycles = 0;
		writeReg(`BLOCK_NUM, regTx, tx);
		// Lands while busy, must be dropped
		if (dropTest)
			writeReg(`BLOCK_NUM, regTx, ~tx);
		waitXfer(64 * (int'(div) + 1) + 16);
		assert (lowCycles == expCycles)
		else
		begin
			errCount++;
			$display("[ERROR] spiCs low cycles got %h expected %h", lowCycles, expCycles);
		end
		readReg(`BLOCK_NUM, regStatus, 32'h2, "status after done");
		readReg(`BLOCK_NUM, regRx, expRx, "rx word");
		readReg(`BLOCK_NUM, regStatus, 32'h0, "status after rx read");
		readReg(`BLOCK_NUM, regTx, tx, "tx kept");
		assert (captured == expMosi && int'(capCount) == nBits)
		else
		begin
			errCount++;
			$display("[ERROR] spiMosi bits got %h (%h) expected %h (%h)",
				captured, capCount, expMosi, nBits);
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial
	begin
		logic [31:0] rTx;
		logic [31:0] rPre;
		logic [4:0]  rLen;
		logic [15:0] rDiv;
		rst = 1'b1;
		busWd = '0;
		busAdrs = '0;
		busWCke = 1'b0;
		busRCke = 1'b0;
		preload = '0;
		seed = 32'ha428_5956;
		repeat (16) @(posedge sysClk);
		@(negedge sysClk);
		rst = 1'b0;

		// Reset values
		assert (spiCs === 1'b1 && spiSck === 1'b0)
		else
		begin
			errCount++;
			$display("[ERROR] spiCs/spiSck got %h/%h expected 1/0", spiCs, spiSck);
		end
		readReg(`BLOCK_NUM, regCtrl, 32'd0, "ctrl reset");
		readReg(`BLOCK_NUM, regDiv, 32'(`DIV_RESET), "div reset");
		readReg(`BLOCK_NUM, regLen, 32'd0, "len reset");
		readReg(`BLOCK_NUM, regStatus, 32'd0, "status reset");

		// Enable still clear, TX must not start
		writeReg(`BLOCK_NUM, regLen, 32'd8);
		writeReg(`BLOCK_NUM, regTx, 32'hA5A5_A5A5);
		for (int i = 0; i < 40; i++)
		begin
			@(negedge sysClk);
			assert (spiCs === 1'b1)
			else
			begin
				errCount++;
				$display("[ERROR] spiCs got %h expected 1 with enable clear", spiCs);
			end
		end
		readReg(`BLOCK_NUM, regStatus, 32'd0, "status disabled");

		// Field masking
		writeReg(`BLOCK_NUM, regCtrl, 32'hFFFF_FFFF);
		writeReg(`BLOCK_NUM, regDiv, 32'hABCD_1234);
		writeReg(`BLOCK_NUM, regLen, 32'hFFFF_FFE7);
		readReg(`BLOCK_NUM, regCtrl, 32'd1, "ctrl masked");
		readReg(`BLOCK_NUM, regDiv, 32'h1234, "div masked");
		readReg(`BLOCK_NUM, regLen, 32'h07, "len masked");

		// Foreign block number
		writeReg(8'h05, regCtrl, 32'd0);
		writeReg(8'h05, regDiv, 32'h77);
		writeReg(8'h05, regLen, 32'h03);
		readReg(8'h05, regCtrl, 32'd0, "foreign ctrl");
		readReg(8'h05, regStatus, 32'd0, "foreign status");
		readReg(`BLOCK_NUM, regCtrl, 32'd1, "ctrl kept");
		readReg(`BLOCK_NUM, regDiv, 32'h1234, "div kept");
		readReg(`BLOCK_NUM, regLen, 32'h07, "len kept");

		// Full word, then random transfers
		runXfer(32'hDEAD_BEEF, 5'd0, 16'd0, 32'h1357_9BDF, 1'b0);
		for (int k = 0; k < 8; k++)
		begin
			rTx = $random(seed);
			rLen = 5'($random(seed));
			rDiv = 16'($random(seed) & 3);
			rPre = $random(seed);
			runXfer(rTx, rLen, rDiv, rPre, 1'b0);
		end

		// Second TX while busy
		runXfer(32'h0000_C3A5, 5'd16, 16'd2, 32'h9F0E_5A11, 1'b1);

		$display("Summary: %0d errors, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+design
design/spiBusPkg.sv
design/spiLinkPkg.sv
design/spiCsrDecode.sv
design/spiShiftEngine.sv
design/spiReadback.sv
design/spiBlock.sv
sim/spiSlaveModel.sv
sim/spiBlockTb.sv

// File: Makefile
SIM      = verilator
TOP      = spiBlockTb
FILELIST = filelist.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
